// File: hdl/win_geom_pkg.sv
package win_geom_pkg;

    // ******************************
    // Image size
    // ******************************
    localparam int ROWS = 11;                   // Image height.
    localparam int COLS = 11;                   // Image width.

    // ******************************
    // Kernel size
    // ******************************
    localparam int KSIZE = 9;                   // Window side.
    localparam int KHALF = KSIZE / 2;           // Taps on each side of the centre.

    // Flush beats push the last columns through the window.
    localparam int BAND_BEATS = COLS + KHALF;

    // ******************************
    // Widths
    // ******************************
    localparam int ROW_W = $clog2(ROWS);        // Band row counter.
    localparam int COL_W = $clog2(BAND_BEATS);  // Beat counter and centre column.

    localparam int PIX_W = 8;                   // Bits per pixel.

endpackage

// File: hdl/win_stream_pkg.sv
package win_stream_pkg;

    // ******************************
    // Payload types
    // ******************************

    // One pixel word.
    typedef logic [win_geom_pkg::PIX_W-1:0] pixel_t;

    // Column slice of one band, px[0] is the top row r-4.
    typedef struct packed {
        pixel_t [win_geom_pkg::KSIZE-1:0] px;
    } column_t;

    // Full window, element 0 is the leftmost column c-4.
    typedef column_t [win_geom_pkg::KSIZE-1:0] window_t;

    // ******************************
    // Sideband types
    // ******************************

    // Centre of a window.
    typedef struct packed {
        logic [win_geom_pkg::ROW_W-1:0] row;
        logic [win_geom_pkg::COL_W-1:0] col;
    } pos_t;

    // Centre lies within KHALF of an image border.
    typedef struct packed {
        logic top;                              // r < KHALF.
        logic bottom;                           // r > ROWS-1-KHALF.
        logic left;                             // c < KHALF.
        logic right;                            // c > COLS-1-KHALF.
    } edge_t;

endpackage

// File: hdl/window_ctrl.sv
`timescale 1ns/100ps

module window_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid_i,
    input  logic                  out_ready_i,
    output logic                  in_ready_o,
    output logic                  shift_en_o,
    output logic                  out_valid_o,
    output logic                  frame_done_o,
    output win_stream_pkg::pos_t  pos_o,
    output win_stream_pkg::edge_t edges_o
);
    import win_geom_pkg::*;
    import win_stream_pkg::*;

    logic             in_xfer;
    logic             out_xfer;
    logic             beat_wrap;
    logic             win_ready;
    logic [COL_W-1:0] beat_q;
    logic [ROW_W-1:0] row_q;
    logic [COL_W-1:0] col_c;
    logic             out_valid_q;
    logic             frame_done_q;
    pos_t             pos_q;
    edge_t            edges_q;
    edge_t            edges_c;

    // ******************************
    // Handshake
    // ******************************
    assign in_ready_o = !out_valid_q || out_ready_i;   // Output slot free after this cycle.
    assign in_xfer    = in_valid_i && in_ready_o;
    assign out_xfer   = out_valid_q && out_ready_i;
    assign shift_en_o = in_xfer;

    assign beat_wrap = (beat_q == COL_W'(BAND_BEATS - 1));
    assign win_ready = (beat_q >= COL_W'(KHALF));      // Priming beats done.

    // ******************************
    // Band position
    // ******************************
    always_ff @(posedge clk) begin
        if (rst) begin
            beat_q <= '0;
            row_q  <= '0;
        end else if (in_xfer) begin
            if (beat_wrap) begin
                beat_q <= '0;
                if (row_q == ROW_W'(ROWS - 1)) begin
                    row_q <= '0;
                end else begin
                    row_q <= row_q + 1'b1;
                end
            end else begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    // Beat j completes the window centred on column j-KHALF.
    assign col_c = beat_q - COL_W'(KHALF);

    assign edges_c.top    = (row_q < ROW_W'(KHALF));
    assign edges_c.bottom = (row_q > ROW_W'(ROWS - 1 - KHALF));
    assign edges_c.left   = (col_c < COL_W'(KHALF));
    assign edges_c.right  = (col_c > COL_W'(COLS - 1 - KHALF));

    // ******************************
    // Output slot
    // ******************************
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q <= 1'b0;
        end else if (in_xfer && win_ready) begin
            out_valid_q <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_q <= 1'b0;                       // Drained, nothing new.
        end
    end

    always_ff @(posedge clk) begin
        if (in_xfer && win_ready) begin
            pos_q.row <= row_q;
            pos_q.col <= col_c;
            edges_q   <= edges_c;
        end
    end

    // Last window of the frame has left.
    always_ff @(posedge clk) begin
        if (rst) begin
            frame_done_q <= 1'b0;
        end else begin
            frame_done_q <= out_xfer && (pos_q.row == ROW_W'(ROWS - 1)) &&
                            (pos_q.col == COL_W'(COLS - 1));
        end
    end

    assign out_valid_o  = out_valid_q;
    assign frame_done_o = frame_done_q;
    assign pos_o        = pos_q;
    assign edges_o      = edges_q;

    // ******************************
    // Checks
    // ******************************
    a_out_hold: assert property (
        @(posedge clk) disable iff (rst)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(pos_o)
    ) else $error("window_ctrl: output dropped or changed under back-pressure");

    a_beat_range: assert property (
        @(posedge clk) disable iff (rst)
        beat_q < COL_W'(BAND_BEATS)
    ) else $error("window_ctrl: beat counter out of range");

endmodule

// File: hdl/column_window.sv
`timescale 1ns/100ps

module column_window (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    shift_en_i,
    input  win_stream_pkg::column_t col_i,
    output win_stream_pkg::window_t win_o
);
    import win_stream_pkg::*;

    window_t win_q;

    // ******************************
    // Column shift register
    // ******************************
    // Oldest column sits at index 0, the new slice enters at the top index.
    always_ff @(posedge clk) begin
        if (rst) begin
            win_q <= '0;
        end else if (shift_en_i) begin
            for (int k = 0; k < $high(win_q); k++) begin
                win_q[k] <= win_q[k+1];             // Move one column left.
            end
            win_q[$high(win_q)] <= col_i;           // Newest column.
        end
    end

    assign win_o = win_q;

    // ******************************
    // Checks
    // ******************************
    a_hold_no_shift: assert property (
        @(posedge clk) disable iff (rst)
        !shift_en_i |=> $stable(win_o)
    ) else $error("column_window: window changed without a shift");

endmodule

// File: hdl/border_mask.sv
`timescale 1ns/100ps

module border_mask (
    input  win_stream_pkg::window_t win_i,
    input  win_stream_pkg::pos_t    pos_i,
    input  win_stream_pkg::edge_t   edges_i,
    output win_stream_pkg::window_t win_o
);
    import win_geom_pkg::*;
    import win_stream_pkg::*;

    logic [KSIZE-1:0] row_out;                  // Tap row lies outside the image.
    logic [KSIZE-1:0] col_out;                  // Tap column lies outside the image.

    // ******************************
    // Row rule
    // ******************************
    // The edge flag is false for interior centres, so no compare is needed there.
    for (genvar dr = 0; dr < KSIZE; dr++) begin : g_row
        if (dr < KHALF) begin : g_above
            assign row_out[dr] = edges_i.top && (pos_i.row < ROW_W'(KHALF - dr));
        end else if (dr > KHALF) begin : g_below
            assign row_out[dr] = edges_i.bottom &&
                                 (pos_i.row > ROW_W'(ROWS - 1 - (dr - KHALF)));
        end else begin : g_centre
            assign row_out[dr] = 1'b0;          // Centre row is always inside.
        end
    end

    // ******************************
    // Column rule
    // ******************************
    for (genvar dc = 0; dc < KSIZE; dc++) begin : g_col
        if (dc < KHALF) begin : g_left
            assign col_out[dc] = edges_i.left && (pos_i.col < COL_W'(KHALF - dc));
        end else if (dc > KHALF) begin : g_right
            assign col_out[dc] = edges_i.right &&
                                 (pos_i.col > COL_W'(COLS - 1 - (dc - KHALF)));
        end else begin : g_centre
            assign col_out[dc] = 1'b0;
        end
    end

    // ******************************
    // Tap masking
    // ******************************
    // Stale columns of the last band and flush columns land in col_out taps.
    for (genvar dc = 0; dc < KSIZE; dc++) begin : g_tap_col
        for (genvar dr = 0; dr < KSIZE; dr++) begin : g_tap_row
            assign win_o[dc].px[dr] = (row_out[dr] || col_out[dc]) ? '0 : win_i[dc].px[dr];
        end
    end

endmodule

// File: hdl/window_gen_top.sv
`timescale 1ns/100ps

module window_gen_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid_i,
    input  logic                    out_ready_i,
    input  win_stream_pkg::column_t col_i,
    output logic                    in_ready_o,
    output logic                    out_valid_o,
    output logic                    frame_done_o,
    output win_stream_pkg::window_t win_o,
    output win_stream_pkg::pos_t    pos_o
);
    import win_stream_pkg::*;

    logic    shift_en;
    pos_t    pos;
    edge_t   edges;
    window_t win_raw;

    // ******************************
    // Control
    // ******************************
    window_ctrl ctrl_i (
        .clk          (clk),
        .rst          (rst),
        .in_valid_i   (in_valid_i),
        .out_ready_i  (out_ready_i),
        .in_ready_o   (in_ready_o),
        .shift_en_o   (shift_en),
        .out_valid_o  (out_valid_o),
        .frame_done_o (frame_done_o),
        .pos_o        (pos),
        .edges_o      (edges)
    );

    // ******************************
    // Datapath
    // ******************************
    column_window window_i (
        .clk        (clk),
        .rst        (rst),
        .shift_en_i (shift_en),
        .col_i      (col_i),
        .win_o      (win_raw)
    );

    border_mask mask_i (
        .win_i   (win_raw),
        .pos_i   (pos),
        .edges_i (edges),
        .win_o   (win_o)                        // Zero latency.
    );

    assign pos_o = pos;

endmodule

// File: tb/tb_window_gen.sv
`timescale 1ns/100ps

module tb_window_gen;
    import win_geom_pkg::*;
    import win_stream_pkg::*;

    localparam int WAIT_LIMIT = 200;            // Cycles allowed per wait loop.
    localparam int FRAME_WINS = ROWS * COLS;

    logic    clk;
    logic    rst;
    logic    in_valid_i;
    logic    out_ready_i;
    column_t col_i;
    logic    in_ready_o;
    logic    out_valid_o;
    logic    frame_done_o;
    window_t win_o;
    pos_t    pos_o;

    integer  seed;
    int      errors;
    int      tests_run;
    int      tests_failed;
    int      test_err_base;
    string   cur_test;
    bit      aborted;

    bit      stall_on;                          // Random out_ready_i phases.
    int      ready_pct;
    int      phase_left;
    int      windows_seen;
    int      done_pulses;
    bit      exp_valid_known;
    bit      exp_valid;
    bit      exp_done;
    int      band;
    int      beat;

    column_t img [ROWS][COLS];                  // Slices of the current frame.
    window_t exp_win_q[$];

    initial clk = 1'b0;
    always #10 clk = ~clk;

    window_gen_top dut_i (
        .clk          (clk),
        .rst          (rst),
        .in_valid_i   (in_valid_i),
        .out_ready_i  (out_ready_i),
        .col_i        (col_i),
        .in_ready_o   (in_ready_o),
        .out_valid_o  (out_valid_o),
        .frame_done_o (frame_done_o),
        .win_o        (win_o),
        .pos_o        (pos_o)
    );

    // ******************************
    // Protocol assertions
    // ******************************
    a_hold_window: assert property (
        @(posedge clk) disable iff (rst)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(win_o) && $stable(pos_o)
    ) else begin
        errors++;
        $display("%s: window dropped or changed while out_ready_i was low", cur_test);
    end

    a_done_single: assert property (
        @(posedge clk) disable iff (rst)
        frame_done_o |=> !frame_done_o
    ) else begin
        errors++;
        $display("%s: frame_done_o stayed high for more than one cycle", cur_test);
    end

    a_ready_when_free: assert property (
        @(posedge clk) disable iff (rst)
        !out_valid_o |-> in_ready_o
    ) else begin
        errors++;
        $display("%s: in_ready_o low with an empty output slot", cur_test);
    end

    // ******************************
    // Model
    // ******************************
    function automatic bit tap_outside(int r, int c, int dr, int dc);
        int row;
        int col;
        row = r - KHALF + dr;
        col = c - KHALF + dc;
        return (row < 0) || (row >= ROWS) || (col < 0) || (col >= COLS);
    endfunction

    // Tap (dr, dc) is pixel dr of slice c-4+dc in band r.
    function automatic window_t expected_window(int r, int c);
        window_t w;
        w = '0;
        for (int dc = 0; dc < KSIZE; dc++) begin
            for (int dr = 0; dr < KSIZE; dr++) begin
                if (!tap_outside(r, c, dr, dc)) begin
                    w[dc].px[dr] = img[r][c - KHALF + dc].px[dr];
                end
            end
        end
        return w;
    endfunction

    function automatic column_t random_column();
        column_t s;
        for (int k = 0; k < KSIZE; k++) begin
            s.px[k] = pixel_t'($random(seed));
            if (s.px[k] == '0) begin
                s.px[k] = 8'h5a;                // Keeps padding visible.
            end
        end
        return s;
    endfunction

    // ******************************
    // Checks
    // ******************************
    task automatic check_value(string what, logic [63:0] expected, logic [63:0] actual);
        assert (expected === actual) else begin
            errors++;
            $display("FAILED %s %s expected %0h actual %0h", cur_test, what, expected, actual);
        end
    endtask

    task automatic check_window();
        window_t exp_w;
        pos_t    exp_pos;
        int      n;
        int      r;
        int      c;
        n = windows_seen % FRAME_WINS;
        r = n / COLS;
        c = n % COLS;
        exp_pos.row = ROW_W'(r);
        exp_pos.col = COL_W'(c);
        check_value("pos_o", exp_pos, pos_o);
        if (exp_win_q.size() == 0) begin
            errors++;
            $display("%s: window sent when none was expected", cur_test);
        end else begin
            exp_w = exp_win_q.pop_front();
            for (int dc = 0; dc < KSIZE; dc++) begin
                for (int dr = 0; dr < KSIZE; dr++) begin
                    check_value($sformatf("tap dr%0d dc%0d", dr, dc),
                                exp_w[dc].px[dr], win_o[dc].px[dr]);
                    if (tap_outside(r, c, dr, dc)) begin
                        check_value($sformatf("border tap dr%0d dc%0d", dr, dc),
                                    '0, win_o[dc].px[dr]);
                    end
                end
            end
        end
        windows_seen++;
    endtask

    // ******************************
    // Cycle driver
    // ******************************
    // Drives one falling edge and predicts what the next one must show.
    task automatic run_cycle(input bit valid, input column_t data, output bit in_xfer);
        bit out_xfer;
        bit exp_ready;
        @(negedge clk);
        if (phase_left == 0) begin
            phase_left = 8 + ($unsigned($random(seed)) % 24);
            case ($unsigned($random(seed)) % 4)
                0: ready_pct = 100;
                1: ready_pct = 70;
                2: ready_pct = 40;
                default: ready_pct = 15;
            endcase
        end
        phase_left--;
        out_ready_i = stall_on ? (($unsigned($random(seed)) % 100) < ready_pct) : 1'b1;
        in_valid_i  = valid;
        col_i       = data;
        #1;
        if (exp_valid_known) begin
            check_value("out_valid_o", exp_valid, out_valid_o);
        end
        check_value("frame_done_o", exp_done, frame_done_o);
        // A pending window blocks input unless it leaves this cycle.
        exp_ready = (exp_win_q.size() == 0) || out_ready_i;
        check_value("in_ready_o", exp_ready, in_ready_o);
        if (frame_done_o) begin
            done_pulses++;
        end
        out_xfer = out_valid_o && out_ready_i;
        in_xfer  = in_valid_i && in_ready_o;
        exp_done = out_xfer && ((windows_seen % FRAME_WINS) == FRAME_WINS - 1);
        if (out_xfer) begin
            check_window();
        end
        exp_valid_known = in_xfer || out_xfer;
        exp_valid       = 1'b0;
        if (in_xfer) begin
            if (beat < COLS) begin
                img[band][beat] = data;
            end
            if (beat >= KHALF) begin
                exp_win_q.push_back(expected_window(band, beat - KHALF));
                exp_valid = 1'b1;
            end
            beat++;
            if (beat == BAND_BEATS) begin
                beat = 0;
                band = (band + 1) % ROWS;
            end
        end
    endtask

    task automatic send_frame(input bit gaps);
        column_t data;
        bit      xfer;
        int      waited;
        int      idle;
        for (int b = 0; b < ROWS * BAND_BEATS && !aborted; b++) begin
            data = random_column();             // Flush beats carry data too.
            idle = gaps ? ($unsigned($random(seed)) % 3) : 0;
            for (int k = 0; k < idle; k++) begin
                run_cycle(1'b0, data, xfer);
            end
            xfer   = 1'b0;
            waited = 0;
            while (!xfer && !aborted) begin
                run_cycle(1'b1, data, xfer);
                waited++;
                if (!xfer && waited >= WAIT_LIMIT) begin
                    errors++;
                    aborted = 1'b1;
                    $display("%s: timeout waiting for in_ready_o", cur_test);
                end
            end
        end
    endtask

    task automatic drain();
        bit xfer;
        int waited;
        waited = 0;
        while (exp_win_q.size() != 0 && !aborted) begin
            run_cycle(1'b0, '0, xfer);
            waited++;
            if (exp_win_q.size() != 0 && waited >= WAIT_LIMIT) begin
                errors++;
                aborted = 1'b1;
                $display("%s: timeout waiting for the last windows", cur_test);
            end
        end
        for (int k = 0; k < 3 && !aborted; k++) begin
            run_cycle(1'b0, '0, xfer);          // Late frame_done_o or extra windows.
        end
    endtask

    // ******************************
    // Test bookkeeping
    // ******************************
    task automatic begin_test(string name);
        cur_test      = name;
        test_err_base = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_err_base) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", cur_test, errors - test_err_base);
        end
    endtask

    task automatic frame_test(string name, bit stalls, bit gaps, int frames);
        int win_base;
        int done_base;
        begin_test(name);
        stall_on  = stalls;
        win_base  = windows_seen;
        done_base = done_pulses;
        for (int f = 0; f < frames && !aborted; f++) begin
            send_frame(gaps);                   // Frames follow back to back.
        end
        drain();
        if (!aborted) begin
            check_value("window count", frames * FRAME_WINS, windows_seen - win_base);
            check_value("frame_done pulses", frames, done_pulses - done_base);
        end
        end_test();
    endtask

    // ******************************
    // Main sequence
    // ******************************
    initial begin
        seed            = 32'h1c24;
        errors          = 0;
        tests_run       = 0;
        tests_failed    = 0;
        aborted         = 1'b0;
        stall_on        = 1'b0;
        ready_pct       = 100;
        phase_left      = 0;
        windows_seen    = 0;
        done_pulses     = 0;
        exp_valid_known = 1'b0;
        exp_valid       = 1'b0;
        exp_done        = 1'b0;
        band            = 0;
        beat            = 0;
        cur_test        = "reset_state";
        rst             = 1'b1;
        in_valid_i      = 1'b0;
        out_ready_i     = 1'b0;
        col_i           = '0;

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        #1;
        begin_test("reset_state");
        check_value("out_valid_o", 1'b0, out_valid_o);
        check_value("frame_done_o", 1'b0, frame_done_o);
        check_value("in_ready_o", 1'b1, in_ready_o);
        end_test();

        frame_test("frame_no_stall", 1'b0, 1'b0, 1);
        frame_test("frame_random_stall", 1'b1, 1'b1, 1);
        frame_test("frames_back_to_back", 1'b1, 1'b0, 2);

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0 && !aborted) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: files.f
hdl/win_geom_pkg.sv
hdl/win_stream_pkg.sv
hdl/window_ctrl.sv
hdl/column_window.sv
hdl/border_mask.sv
hdl/window_gen_top.sv
tb/tb_window_gen.sv

// File: Bender.yml
package:
  name: window_gen

sources:
  - hdl/win_geom_pkg.sv
  - hdl/win_stream_pkg.sv
  - hdl/window_ctrl.sv
  - hdl/column_window.sv
  - hdl/border_mask.sv
  - hdl/window_gen_top.sv
  - target: test
    files:
      - tb/tb_window_gen.sv
